//--- tcu_dot_unit.f
+incdir+.
tcu_fmt_pkg.sv
tcu_data_pkg.sv
tcu_operand_unpack.sv
tcu_shared_mul.sv
tcu_lane_reduce.sv
tcu_dot_unit.sv
tcu_dot_unit_tb.sv

//--- tcu_dot_unit_tb.sv
`timescale 1ns/1ps
`include "tcu_defs.svh"

module tcu_dot_unit_tb;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_TABLE    = 12;
    localparam int NUM_RANDOM   = 40;
    localparam int LATENCY      = 3;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_TABLE + NUM_RANDOM + LATENCY + 20;

    // One outstanding result and the cycle its request was driven
    typedef struct packed {
        tcu_data_pkg::tcu_acc_t value;
        logic [31:0]            issued;
    } expect_t;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    tcu_data_pkg::tcu_req_t req;
    logic                   res_valid;
    tcu_data_pkg::tcu_acc_t res;

    string                  tbl_name  [NUM_TABLE];
    tcu_data_pkg::tcu_req_t tbl_req   [NUM_TABLE];
    logic                   tbl_fixed [NUM_TABLE];
    tcu_data_pkg::tcu_acc_t tbl_exp   [NUM_TABLE];

    expect_t     exp_q[$];
    string       name_q[$];
    int unsigned cycle = 0;
    int unsigned pass_count;
    int unsigned fail_count;
    integer      seed;

    tcu_dot_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Element k of a packed word, read as a signed or unsigned integer
    function automatic longint field_value(input logic [31:0] word, input int k,
                                           input int width, input logic sgn);
        longint v;
        v = (64'(word) >> (k * width)) & ((64'd1 << width) - 1);
        if (sgn && v >= (64'd1 << (width - 1))) begin
            v = v - (64'd1 << width);
        end
        return v;
    endfunction

    // C plus the products of all unmasked elements, wrapped to 32 bits
    function automatic tcu_data_pkg::tcu_acc_t dot_ref(input tcu_data_pkg::tcu_req_t r);
        longint acc;
        int     width;
        logic   sgn;
        acc   = r.c_val;
        width = (r.fmt == tcu_fmt_pkg::FMT_I4 || r.fmt == tcu_fmt_pkg::FMT_U4) ? 4 : 8;
        sgn   = (r.fmt == tcu_fmt_pkg::FMT_I8 || r.fmt == tcu_fmt_pkg::FMT_I4);
        for (int w = 0; w < `TCU_N; w++) begin
            if (r.mask[w]) begin
                for (int k = 0; k < 32 / width; k++) begin
                    acc += field_value(r.a_row[w], k, width, sgn) *
                           field_value(r.b_col[w], k, width, sgn);
                end
            end
        end
        return acc[`TCU_DW-1:0];
    endfunction

    // Even words take the first pattern, odd words the second
    task automatic add_entry(input int idx, input string name,
                             input tcu_fmt_pkg::tcu_fmt_e fmt, input logic [`TCU_N-1:0] mask,
                             input tcu_data_pkg::tcu_word_t a0, input tcu_data_pkg::tcu_word_t a1,
                             input tcu_data_pkg::tcu_word_t b0, input tcu_data_pkg::tcu_word_t b1,
                             input tcu_data_pkg::tcu_acc_t c, input logic fixed,
                             input tcu_data_pkg::tcu_acc_t exp_val);
        tcu_data_pkg::tcu_req_t r;
        r.fmt  = fmt;
        r.mask = mask;
        for (int w = 0; w < `TCU_N; w++) begin
            r.a_row[w] = (w % 2 == 0) ? a0 : a1;
            r.b_col[w] = (w % 2 == 0) ? b0 : b1;
        end
        r.c_val        = c;
        tbl_name[idx]  = name;
        tbl_req[idx]   = r;
        tbl_fixed[idx] = fixed;
        tbl_exp[idx]   = exp_val;
    endtask

    task automatic load_table();
        add_entry(0, "i8_mixed", tcu_fmt_pkg::FMT_I8, 2'b11, 32'h807F_FF02, 32'h0102_0304,
                  32'h8081_0503, 32'hFFFE_FDFC, 32'd1000, 1'b1, 32'h0000_04CA);
        add_entry(1, "u8_max_wrap", tcu_fmt_pkg::FMT_U8, 2'b11, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_0000, 1'b1, 32'h0006_F008);
        add_entry(2, "i4_extremes", tcu_fmt_pkg::FMT_I4, 2'b11, 32'h8888_8888, 32'h1234_5678,
                  32'h8888_8888, 32'hFFFF_FFFF, 32'd0, 1'b1, 32'h0000_01EC);
        add_entry(3, "u4_max", tcu_fmt_pkg::FMT_U4, 2'b11, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd5, 1'b1, 32'h0000_0E15);
        add_entry(4, "mask_low_i8", tcu_fmt_pkg::FMT_I8, 2'b01, 32'h807F_FF02, 32'h0102_0304,
                  32'h8081_0503, 32'hFFFE_FDFC, 32'd1000, 1'b1, 32'h0000_04E8);
        add_entry(5, "mask_high_u8", tcu_fmt_pkg::FMT_U8, 2'b10, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd0, 1'b1, 32'h0003_F804);
        add_entry(6, "mask_none", tcu_fmt_pkg::FMT_U4, 2'b00, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hDEAD_BEEF, 1'b1, 32'hDEAD_BEEF);
        // Alternating formats back to back, checked against the model only
        add_entry(7, "pipe_i8", tcu_fmt_pkg::FMT_I8, 2'b11, 32'h9C40_7F81, 32'h00FF_8001,
                  32'h7F80_0102, 32'hC3A5_5A3C, 32'hFFFF_FF00, 1'b0, '0);
        add_entry(8, "pipe_u4", tcu_fmt_pkg::FMT_U4, 2'b11, 32'h0123_4567, 32'h89AB_CDEF,
                  32'hFEDC_BA98, 32'h7654_3210, 32'h1234_5678, 1'b0, '0);
        add_entry(9, "pipe_u8", tcu_fmt_pkg::FMT_U8, 2'b01, 32'h80FF_0110, 32'hAAAA_5555,
                  32'h7FFF_FE20, 32'h5555_AAAA, 32'd7, 1'b0, '0);
        add_entry(10, "pipe_i4", tcu_fmt_pkg::FMT_I4, 2'b11, 32'h7878_8787, 32'hF0F0_0F0F,
                  32'h8787_7878, 32'h1E1E_E1E1, 32'h8000_0000, 1'b0, '0);
        add_entry(11, "pipe_i8_tail", tcu_fmt_pkg::FMT_I8, 2'b10, 32'h1122_3344, 32'h8080_8080,
                  32'h5566_7788, 32'h8080_8080, 32'hFFFF_FFFF, 1'b0, '0);
    endtask

    // Drive one request a little after the rising edge and queue its expected result
    task automatic issue(input string name, input tcu_data_pkg::tcu_req_t r,
                         input logic fixed, input tcu_data_pkg::tcu_acc_t fixed_val);
        expect_t                e;
        tcu_data_pkg::tcu_acc_t model;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req       = r;
        model     = dot_ref(r);
        if (fixed) begin
            assert (model == fixed_val) else begin
                $display("Reference model gives 0x%08h for %s but the table holds 0x%08h",
                         model, name, fixed_val);
                fail_count++;
            end
        end
        e.value  = fixed ? fixed_val : model;
        e.issued = cycle;
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic run_random();
        tcu_data_pkg::tcu_req_t r;
        logic [31:0]            rnd;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd    = $random(seed);
            r.fmt  = tcu_fmt_pkg::tcu_fmt_e'(rnd[1:0]);
            rnd    = $random(seed);
            r.mask = rnd[`TCU_N-1:0];
            for (int w = 0; w < `TCU_N; w++) begin
                r.a_row[w] = $random(seed);
                r.b_col[w] = $random(seed);
            end
            r.c_val = $random(seed);
            issue($sformatf("rand_%0d", i), r, 1'b0, '0);
        end
    endtask

    // Outputs are sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        expect_t e;
        string   name;
        logic    ok;
        if (res_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("Unexpected result 0x%08h with no request outstanding", res);
                fail_count++;
            end
            if (exp_q.size() > 0) begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                ok   = 1'b1;
                assert (res == e.value) else begin
                    $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, e.value, res);
                    ok = 1'b0;
                end
                assert (cycle - e.issued == LATENCY) else begin
                    $display("Result of %s arrived %0d cycles after its request, not %0d",
                             name, cycle - e.issued, LATENCY);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_count++;
                    $display("[PASS] %s 0x%08h", name, res);
                end else begin
                    fail_count++;
                    $display("[FAIL] %s", name);
                end
            end
        end
    end

    initial begin
        while (cycle < CYCLE_LIMIT) @(posedge clk);
        $display("Timeout at cycle %0d with %0d results never returned", cycle, exp_q.size());
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        pass_count = 0;
        fail_count = 0;
        seed       = 32'he3a6_4b17;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_TABLE; i++) begin
            issue(tbl_name[i], tbl_req[i], tbl_fixed[i], tbl_exp[i]);
        end
        run_random();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        req       = '0;
        while (exp_q.size() > 0) @(negedge clk);
        // A few idle cycles to catch a stray strobe
        repeat (4) @(negedge clk);
        $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- tcu_dot_unit.sv
`timescale 1ns/1ps

module tcu_dot_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  tcu_data_pkg::tcu_req_t req,
    output logic                   res_valid,
    output tcu_data_pkg::tcu_acc_t res
);

    // Stage 1 to stage 2
    logic                        up_valid;
    tcu_data_pkg::tcu_unpacked_t up_data;

    // Stage 2 to stage 3
    logic                        pp_valid;
    tcu_data_pkg::tcu_partials_t pp_data;

    tcu_operand_unpack unpack_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .up_valid  (up_valid),
        .up_data   (up_data)
    );

    tcu_shared_mul mul_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .up_valid (up_valid),
        .up_data  (up_data),
        .pp_valid (pp_valid),
        .pp_data  (pp_data)
    );

    tcu_lane_reduce reduce_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pp_valid  (pp_valid),
        .pp_data   (pp_data),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

//--- tcu_lane_reduce.sv
`timescale 1ns/1ps
`include "tcu_defs.svh"

module tcu_lane_reduce (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pp_valid,
    input  tcu_data_pkg::tcu_partials_t pp_data,
    output logic                        res_valid,
    output tcu_data_pkg::tcu_acc_t      res
);

    localparam int SLICES = `TCU_SLICES;
    localparam int PW     = `TCU_PW;
    localparam int DW     = `TCU_DW;
    // All partials plus the C term
    localparam int TERMS  = SLICES + 1;
    localparam int NODES  = 2 * TERMS - 1;

    // Heap-ordered adder tree with the root at node 0
    // Node i adds nodes 2i+1 and 2i+2
    // The last TERMS nodes are the leaves
    tcu_data_pkg::tcu_acc_t [NODES-1:0] tree;

    for (genvar l = 0; l < TERMS; l++) begin : g_leaf
        if (l < SLICES) begin : g_part
            assign tree[TERMS - 1 + l] =
                {{(DW - PW){pp_data.partial[l][PW-1]}}, pp_data.partial[l]};
        end else begin : g_c
            assign tree[TERMS - 1 + l] = pp_data.c_val;
        end
    end

    // Sums wrap modulo 2^DW
    for (genvar n = 0; n < TERMS - 1; n++) begin : g_node
        assign tree[n] = tree[2 * n + 1] + tree[2 * n + 2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= pp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pp_valid) begin
            res <= tree[0];
        end
    end

endmodule

//--- tcu_shared_mul.sv
`timescale 1ns/1ps
`include "tcu_defs.svh"

module tcu_shared_mul (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        up_valid,
    input  tcu_data_pkg::tcu_unpacked_t up_data,
    output logic                        pp_valid,
    output tcu_data_pkg::tcu_partials_t pp_data
);

    localparam int SLICES = `TCU_SLICES;
    localparam int ELEMS  = `TCU_ELEMS;
    localparam int EW     = `TCU_EW;
    localparam int PW     = `TCU_PW;
    localparam int MW     = 2 * EW;

    tcu_data_pkg::tcu_partials_t pp_next;

    // Bitwise majority, the carry half of a 3:2 compressor
    function automatic logic [PW-1:0] maj(
        input logic [PW-1:0] x,
        input logic [PW-1:0] y,
        input logic [PW-1:0] z
    );
        return (x & y) | (x & z) | (y & z);
    endfunction

    for (genvar s = 0; s < SLICES; s++) begin : g_slice
        logic [ELEMS-1:0][MW-1:0] prod;
        logic [ELEMS-1:0][PW-1:0] prod_ext;
        logic [PW-1:0]            sum_1;
        logic [PW-1:0]            cry_1;
        logic [PW-1:0]            sum_2;
        logic [PW-1:0]            cry_2;

        // Same four signed multipliers for every format
        for (genvar e = 0; e < ELEMS; e++) begin : g_mul
            assign prod[e] = $signed(up_data.a_elem[s][e]) * $signed(up_data.b_elem[s][e]);
            assign prod_ext[e] = {{(PW - MW){prod[e][MW-1]}}, prod[e]};
        end

        // Two 3:2 stages fold four products into a sum and carry pair
        assign sum_1 = prod_ext[0] ^ prod_ext[1] ^ prod_ext[2];
        assign cry_1 = maj(prod_ext[0], prod_ext[1], prod_ext[2]) << 1;
        assign sum_2 = sum_1 ^ cry_1 ^ prod_ext[3];
        assign cry_2 = maj(sum_1, cry_1, prod_ext[3]) << 1;

        // Carry-propagate adder, wraps at PW bits which the true sum never exceeds
        assign pp_next.partial[s] = sum_2 + cry_2;
    end

    assign pp_next.c_val = up_data.c_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= up_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up_valid) begin
            pp_data <= pp_next;
        end
    end

endmodule

//--- tcu_operand_unpack.sv
`timescale 1ns/1ps
`include "tcu_defs.svh"

module tcu_operand_unpack (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  tcu_data_pkg::tcu_req_t      req,
    output logic                        up_valid,
    output tcu_data_pkg::tcu_unpacked_t up_data
);

    localparam int SLICES = `TCU_SLICES;
    localparam int ELEMS  = `TCU_ELEMS;

    tcu_data_pkg::tcu_unpacked_t up_next;
    logic                        is_signed;
    logic                        is_nibble;

    // Pick element idx out of a 16-bit slice and extend it to the common width
    function automatic tcu_fmt_pkg::tcu_elem_t widen(
        input logic [15:0] slice,
        input int          idx,
        input logic        nibble,
        input logic        sgn
    );
        logic [3:0] nib;
        logic [7:0] raw;
        nib = slice[(idx % 4) * 4 +: 4];
        if (nibble) begin
            raw = {{4{nib[3] & sgn}}, nib};
        end else if (idx < 2) begin
            raw = slice[(idx % 2) * 8 +: 8];
        end else begin
            // Upper two elements idle in byte mode
            raw = 8'd0;
        end
        return {raw[7] & sgn, raw};
    endfunction

    assign is_signed = tcu_fmt_pkg::fmt_is_signed(req.fmt);
    assign is_nibble = tcu_fmt_pkg::fmt_is_nibble(req.fmt);

    for (genvar s = 0; s < SLICES; s++) begin : g_slice
        localparam int WORD = s / 2;
        localparam int HALF = (s % 2) * 16;

        logic [15:0] a_slice;
        logic [15:0] b_slice;

        // A masked word contributes nothing, zero its slices here
        assign a_slice = req.mask[WORD] ? req.a_row[WORD][HALF +: 16] : 16'd0;
        assign b_slice = req.mask[WORD] ? req.b_col[WORD][HALF +: 16] : 16'd0;

        for (genvar e = 0; e < ELEMS; e++) begin : g_elem
            assign up_next.a_elem[s][e] = widen(a_slice, e, is_nibble, is_signed);
            assign up_next.b_elem[s][e] = widen(b_slice, e, is_nibble, is_signed);
        end
    end

    assign up_next.c_val = req.c_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_valid <= 1'b0;
        end else begin
            up_valid <= req_valid;
        end
    end

    // Payload only moves with a request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            up_data <= up_next;
        end
    end

endmodule

//--- tcu_data_pkg.sv
`include "tcu_defs.svh"

package tcu_data_pkg;

    // Packed row or column word
    typedef logic [31:0] tcu_word_t;

    // C term and result
    typedef logic [`TCU_DW-1:0] tcu_acc_t;

    // Sum of the four products of one slice
    typedef logic [`TCU_PW-1:0] tcu_partial_t;

    // Request as presented by the issuing side
    typedef struct packed {
        tcu_fmt_pkg::tcu_fmt_e          fmt;
        logic [`TCU_N-1:0]              mask;
        tcu_word_t [`TCU_N-1:0]         a_row;
        tcu_word_t [`TCU_N-1:0]         b_col;
        tcu_acc_t                       c_val;
    } tcu_req_t;

    // Operands after unpacking, format no longer matters past this point
    typedef struct packed {
        tcu_fmt_pkg::tcu_elem_t [`TCU_SLICES-1:0][`TCU_ELEMS-1:0] a_elem;
        tcu_fmt_pkg::tcu_elem_t [`TCU_SLICES-1:0][`TCU_ELEMS-1:0] b_elem;
        tcu_acc_t                                                c_val;
    } tcu_unpacked_t;

    // Per-slice partial sums travelling with the C term
    typedef struct packed {
        tcu_partial_t [`TCU_SLICES-1:0] partial;
        tcu_acc_t                       c_val;
    } tcu_partials_t;

endpackage

//--- tcu_fmt_pkg.sv
`include "tcu_defs.svh"

package tcu_fmt_pkg;

    // Integer element formats
    typedef enum logic [1:0] {
        FMT_I8 = 2'd0,
        FMT_U8 = 2'd1,
        FMT_I4 = 2'd2,
        FMT_U4 = 2'd3
    } tcu_fmt_e;

    // One element after widening to a common signed width
    typedef logic [`TCU_EW-1:0] tcu_elem_t;

    // Signed formats take sign extension, the others zero extension
    function automatic logic fmt_is_signed(input tcu_fmt_e fmt);
        return (fmt == FMT_I8) || (fmt == FMT_I4);
    endfunction

    // 4-bit formats pack four elements into a slice
    function automatic logic fmt_is_nibble(input tcu_fmt_e fmt);
        return (fmt == FMT_I4) || (fmt == FMT_U4);
    endfunction

endpackage

//--- tcu_defs.svh
`ifndef TCU_DEFS_SVH
`define TCU_DEFS_SVH

// Number of 32-bit words in one row of A and one column of B
`define TCU_N 2

// Each word is split into two 16-bit slices
`define TCU_SLICES (2 * `TCU_N)

// Widened elements per slice, four nibbles or two bytes plus two zeros
`define TCU_ELEMS 4

// One element after sign or zero extension
`define TCU_EW 9

// Sum of four 18-bit signed products per slice
`define TCU_PW 20

// Accumulator and result width
`define TCU_DW 32

`endif
